/* bench/busMonitor.sv */
`timescale 1ns/100ps

module busMonitor (
  input  logic            sysClk_i,
  input  logic            arstN_i,
  input  memPkg::memReq_t memReq_i,
  input  memPkg::memRsp_t memRsp_i,
  input  logic            halted_i,
  input  int              numExpected_i,
  output int              errors_o,
  output int              storesSeen_o
);

  localparam int MaxStores  = 64;
  localparam int TrackWords = 1024;

  memPkg::addr_t expAddr   [MaxStores];
  cpuPkg::word_t expData   [MaxStores];
  logic          isProgram [TrackWords]; // Marked words only, X elsewhere
  int            readCount [TrackWords];
  int            errCount    = 0;
  int            storeCount  = 0;
  logic          seenRequest = 1'b0;
  logic          haltedSeen  = 1'b0;

  assign errors_o     = errCount;
  assign storesSeen_o = storeCount;

  initial begin
    for (int i = 0; i < TrackWords; i++) begin
      readCount[i] = 0;
    end
  end

  task automatic expectStore(input int slot, input memPkg::addr_t addr,
                             input cpuPkg::word_t data);
    if (slot < MaxStores) begin
      expAddr[slot] = addr;
      expData[slot] = data;
    end
  endtask

  task automatic markProgramWord(input memPkg::addr_t addr);
    if (addr < TrackWords * 4) begin
      isProgram[addr[11:2]] = 1'b1;
    end
  endtask

  // Stores must match the expected list in order
  task automatic checkStore(input memPkg::addr_t addr, input cpuPkg::word_t data);
    if (storeCount >= numExpected_i) begin
      $display("Error: store of %h to %h beyond the %0d expected stores",
               data, addr, numExpected_i);
      errCount++;
    end else begin
      if (addr !== expAddr[storeCount]) begin
        $display("Fail memReq_o.addr expected %h actual %h", expAddr[storeCount], addr);
        errCount++;
      end
      if (data !== expData[storeCount]) begin
        $display("Fail memReq_o.wdata expected %h actual %h", expData[storeCount], data);
        errCount++;
      end
    end
    storeCount++;
  endtask

  // A second read of an image word means the cache missed a line it held
  task automatic countRead(input memPkg::addr_t addr);
    int idx;
    if (addr < TrackWords * 4) begin
      idx = addr[11:2];
      if (isProgram[idx] === 1'b1) begin
        readCount[idx]++;
        if (readCount[idx] > 1) begin
          $display("Error: address %h was read from memory %0d times instead of hitting",
                   addr, readCount[idx]);
          errCount++;
        end
      end
    end
  endtask

  always @(posedge sysClk_i) begin
    if (!arstN_i) begin
      if (memReq_i.valid || halted_i) begin
        $display("Error: memory request or halted_o active during reset");
        errCount++;
      end
    end else begin
      if (!seenRequest && halted_i) begin
        $display("Error: halted_o rose before the first fetch");
        errCount++;
      end
      if (memReq_i.valid && !seenRequest) begin
        seenRequest = 1'b1;
        if (memReq_i.write || memReq_i.addr !== '0) begin
          $display("Error: the first bus request is not a fetch from address 0");
          errCount++;
        end
      end
      if (memReq_i.valid && memRsp_i.ack) begin
        if (memReq_i.write) begin
          checkStore(memReq_i.addr, memReq_i.wdata);
        end else begin
          countRead(memReq_i.addr);
        end
      end
      if (halted_i && !haltedSeen) begin
        haltedSeen = 1'b1;
        if (storeCount != numExpected_i) begin
          $display("Error: halted_o rose after %0d of %0d expected stores",
                   storeCount, numExpected_i);
          errCount++;
        end
      end
      if (halted_i && memReq_i.valid) begin
        $display("Error: memory request to %h after the core halted", memReq_i.addr);
        errCount++;
      end
    end
  end

endmodule

/* bench/cpuSubsys_sva.sv */
`timescale 1ns/100ps

module cpuSubsys_sva (
  input logic              sysClk_i,
  input logic              arstN_i,
  input memPkg::memReq_t   memReq_i,
  input memPkg::memRsp_t   memRsp_i,
  input logic              halted_i,
  input memPkg::cacheReq_t iReq_i,
  input logic              iBusy_i,
  input memPkg::cacheReq_t dReq_i,
  input logic              dBusy_i,
  input memPkg::memReq_t   iMemReq_i,
  input memPkg::memReq_t   dMemReq_i,
  input memPkg::memRsp_t   iMemRsp_i,
  input memPkg::memRsp_t   dMemRsp_i
);

  int failCount = 0;

  // Request held until the memory acknowledges it
  reqStable: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    memReq_i.valid && !memRsp_i.ack |=> $stable(memReq_i))
    else begin
      $error("memReq_o changed while its request was still waiting for ack");
      failCount++;
    end

  // Each cache gets ack only for its own request
  iAckNeedsReq: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    iMemRsp_i.ack |-> iMemReq_i.valid)
    else begin
      $error("Instruction cache ack seen without its valid request");
      failCount++;
    end

  dAckNeedsReq: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    dMemRsp_i.ack |-> dMemReq_i.valid)
    else begin
      $error("Data cache ack seen without its valid request");
      failCount++;
    end

  // Only reset leaves the halted state
  haltSticky: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    halted_i |=> halted_i)
    else begin
      $error("halted_o fell without a reset");
      failCount++;
    end

  iBusyNeedsEn: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    iBusy_i |-> iReq_i.en)
    else begin
      $error("Instruction cache busy without an enable");
      failCount++;
    end

  dBusyNeedsEn: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    dBusy_i |-> dReq_i.en)
    else begin
      $error("Data cache busy without an enable");
      failCount++;
    end

endmodule

bind cpuSubsys cpuSubsys_sva protocolChecks (
  .sysClk_i  (sysClk_i),
  .arstN_i   (arstN_i),
  .memReq_i  (memReq_o),
  .memRsp_i  (memRsp_i),
  .halted_i  (halted_o),
  .iReq_i    (iReq),
  .iBusy_i   (iBusy),
  .dReq_i    (dReq),
  .dBusy_i   (dBusy),
  .iMemReq_i (iMemReq),
  .dMemReq_i (dMemReq),
  .iMemRsp_i (iMemRsp),
  .dMemRsp_i (dMemRsp)
);

/* bench/progInput.txt */
# P <byte address> <word>    program and data image, hex
# E <store address> <data>   expected stores in bus order, hex
P 00000000 20200003
P 00000004 20400100
P 00000008 20600010
# loop adds r1 down to zero into r3
P 0000000c 00630800
P 00000010 2021ffff
P 00000014 bc010008
P 00000018 b800fff4
# load, store hit, load hit
P 0000001c c8a20000
P 00000020 d8620000
P 00000024 c8c20000
P 00000028 04862800
P 0000002c 00042000
P 00000030 00e03000
P 00000034 d8820004
P 00000038 d8e20008
P 0000003c fc000000
# data word read by the first load
P 00000100 00000055
E 00000100 00000016
E 00000104 ffffffc1
E 00000108 00000016

/* bench/tb_cpuSubsys.sv */
`timescale 1ns/100ps

module tb_cpuSubsys;

  localparam int MemWords      = 1024;
  localparam int CyclesPerLine = 64; // Timeout budget per input line
  localparam int DrainCycles   = 8;  // Bus watched this long after halt

  logic            sysClk = 1'b0;
  logic            arstN  = 1'b0;
  memPkg::memReq_t memReq;
  memPkg::memRsp_t memRsp = '0;
  logic            halted;

  cpuPkg::word_t memory [MemWords];
  integer        seed        = 76520;
  int            waitLeft    = 0;
  logic          pending     = 1'b0;
  int            modelErrors = 0;
  int            numProg;
  int            numExp;
  int            tbErrors;
  int            monErrors;
  int            assertErrors;
  int            storesSeen;
  int            cycles;
  int            limit;
  logic          timedOut;

  always #4 sysClk = ~sysClk;

  cpuSubsys i_dut (
    .sysClk_i (sysClk),
    .arstN_i  (arstN),
    .memReq_o (memReq),
    .memRsp_i (memRsp),
    .halted_o (halted)
  );

  busMonitor busCheck (
    .sysClk_i      (sysClk),
    .arstN_i       (arstN),
    .memReq_i      (memReq),
    .memRsp_i      (memRsp),
    .halted_i      (halted),
    .numExpected_i (numExp),
    .errors_o      (monErrors),
    .storesSeen_o  (storesSeen)
  );

  function automatic cpuPkg::word_t fillWord(input memPkg::addr_t addr);
    return addr ^ 32'ha5a5_5a5a;
  endfunction

  // P lines fill the memory and E lines go to the checker
  task automatic loadInputFile();
    integer          fd;
    integer          n;
    logic [7:0]      kind;
    memPkg::addr_t   addr;
    cpuPkg::word_t   data;
    logic [8*80-1:0] rest;
    fd = $fopen("bench/progInput.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open bench/progInput.txt");
      tbErrors++;
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h", addr, data);
          if (n != 2) begin
            $display("Error: malformed line in the input file");
            tbErrors++;
          end else if (kind == "P" && addr < MemWords * 4) begin
            memory[addr[11:2]] = data;
            busCheck.markProgramWord(addr);
            numProg++;
          end else if (kind == "E") begin
            busCheck.expectStore(numExp, addr, data);
            numExp++;
          end else begin
            $display("Error: input line %c %h cannot be used", kind, addr);
            tbErrors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic serveRequest();
    memRsp.rdata = fillWord(memReq.addr);
    if (memReq.addr >= MemWords * 4) begin
      if (memReq.write) begin
        $display("Error: store to %h lies outside the memory model", memReq.addr);
        modelErrors++;
      end
    end else if (memReq.write) begin
      memory[memReq.addr[11:2]] = memReq.wdata;
    end else begin
      memRsp.rdata = memory[memReq.addr[11:2]];
    end
    memRsp.ack = 1'b1;
  endtask

  // Memory model with a random 1 to 4 cycle latency
  always @(negedge sysClk) begin
    if (!arstN) begin
      memRsp  = '0;
      pending = 1'b0;
    end else if (memRsp.ack) begin
      memRsp.ack = 1'b0; // Single-cycle pulse
    end else if (memReq.valid) begin
      if (!pending) begin
        pending  = 1'b1;
        waitLeft = {$random(seed)} % 4;
      end
      if (waitLeft == 0) begin
        serveRequest();
        pending = 1'b0;
      end else begin
        waitLeft--;
      end
    end
  end

  initial begin
    numProg      = 0;
    numExp       = 0;
    tbErrors     = 0;
    assertErrors = 0;
    cycles       = 0;
    timedOut     = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      memory[i] = fillWord(i * 4);
    end
    loadInputFile();
    limit = CyclesPerLine * (numProg + numExp);

    repeat (5) @(negedge sysClk);
    arstN = 1'b1;

    while (!halted && !timedOut) begin
      @(posedge sysClk);
      cycles++;
      timedOut = (cycles >= limit);
    end
    repeat (DrainCycles) @(posedge sysClk);

    if (timedOut) begin
      $display("Error: the core did not halt within %0d cycles", limit);
      tbErrors++;
    end
    assertErrors = i_dut.protocolChecks.failCount;
    $display("Errors: %0d monitor, %0d assertion, %0d model, %0d testbench; %0d/%0d stores",
             monErrors, assertErrors, modelErrors, tbErrors, storesSeen, numExp);
    if (monErrors == 0 && assertErrors == 0 && modelErrors == 0 && tbErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/cpuPkg.sv
hdl/memPkg.sv
hdl/cpuCore.sv
hdl/cacheCtrl.sv
hdl/memArbiter.sv
hdl/cpuSubsys.sv
bench/cpuSubsys_sva.sv
bench/busMonitor.sv
bench/tb_cpuSubsys.sv

/* hdl/cacheCtrl.sv */
`timescale 1ns/100ps

module cacheCtrl (
  input  logic              sysClk_i,
  input  logic              arstN_i,
  // Core side
  input  memPkg::cacheReq_t req_i,
  output logic              busy_o,
  output cpuPkg::word_t     data_o,
  // Memory side
  output memPkg::memReq_t   memReq_o,
  input  memPkg::memRsp_t   memRsp_i
);

  typedef enum logic [1:0] {
    CacheIdle,
    CacheLookup,
    CacheMemWait,
    CacheDone
  } cacheState_t;

  cacheState_t               state;
  memPkg::cacheReq_t         reqReg;
  logic [memPkg::CacheLines-1:0] validArr;
  memPkg::cacheTag_t         tagArr  [memPkg::CacheLines];
  cpuPkg::word_t             dataArr [memPkg::CacheLines];
  logic                      rdValid;
  memPkg::cacheTag_t         rdTag;
  cpuPkg::word_t             rdData;
  logic                      hit;
  logic                      hitReg;
  memPkg::cacheIdx_t         inIdx;
  memPkg::cacheIdx_t         regIdx;
  memPkg::cacheTag_t         regTag;

  assign inIdx  = req_i.addr[memPkg::WordOffsetBits +: memPkg::CacheIndexBits];
  assign regIdx = reqReg.addr[memPkg::WordOffsetBits +: memPkg::CacheIndexBits];
  assign regTag = reqReg.addr[31 -: memPkg::CacheTagBits];
  assign hit    = rdValid && (rdTag == regTag);

  always_ff @(posedge sysClk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      state    <= CacheIdle;
      validArr <= '0;
    end else begin
      case (state)
        CacheIdle: begin
          if (req_i.en) begin
            state <= CacheLookup;
          end
        end
        CacheLookup: begin
          // Stores always go out, write-through
          if (reqReg.we || !hit) begin
            state <= CacheMemWait;
          end else begin
            state <= CacheIdle;
          end
        end
        CacheMemWait: begin
          if (memRsp_i.ack) begin
            state <= CacheDone;
            if (!reqReg.we) begin
              validArr[regIdx] <= 1'b1;
            end
          end
        end
        default: state <= CacheIdle; // CacheDone
      endcase
    end
  end

  // Lookup registers and line storage
  always_ff @(posedge sysClk_i) begin
    if (state == CacheIdle && req_i.en) begin
      reqReg  <= req_i;
      rdValid <= validArr[inIdx];
      rdTag   <= tagArr[inIdx];
      rdData  <= dataArr[inIdx];
    end
    if (state == CacheLookup) begin
      hitReg <= hit;
    end
    if (state == CacheMemWait && memRsp_i.ack) begin
      if (!reqReg.we) begin
        tagArr[regIdx]  <= regTag; // Line fill
        dataArr[regIdx] <= memRsp_i.rdata;
        rdData          <= memRsp_i.rdata;
      end else if (hitReg) begin
        dataArr[regIdx] <= reqReg.wdata; // No allocate on a store miss
      end
    end
  end

  always_comb begin
    case (state)
      CacheIdle:    busy_o = req_i.en;
      CacheLookup:  busy_o = reqReg.we || !hit;
      CacheMemWait: busy_o = 1'b1;
      default:      busy_o = 1'b0;
    endcase
  end

  assign data_o = rdData;

  always_comb begin
    memReq_o.valid = (state == CacheMemWait);
    memReq_o.write = reqReg.we;
    memReq_o.addr  = reqReg.addr;
    memReq_o.wdata = reqReg.wdata;
  end

endmodule

/* hdl/cpuCore.sv */
`timescale 1ns/100ps

module cpuCore (
  input  logic              sysClk_i,
  input  logic              arstN_i,
  // Instruction side
  output memPkg::cacheReq_t iReq_o,
  input  logic              iBusy_i,
  input  cpuPkg::word_t     iData_i,
  // Data side
  output memPkg::cacheReq_t dReq_o,
  input  logic              dBusy_i,
  input  cpuPkg::word_t     dData_i,
  output logic              halted_o
);

  cpuPkg::coreState_t state;
  memPkg::addr_t      pc;
  memPkg::addr_t      nextPc;
  cpuPkg::instr_t     ir;
  cpuPkg::word_t      regFile [32];
  cpuPkg::word_t      opA;
  cpuPkg::word_t      opB;
  cpuPkg::word_t      result;
  cpuPkg::word_t      simm;
  cpuPkg::regIdx_t    rbIdx;
  logic               isMemOp;
  logic               writesReg;

  // Register 0 is hardwired to zero
  function automatic cpuPkg::word_t readReg(input cpuPkg::regIdx_t idx);
    cpuPkg::word_t value;
    value = regFile[idx];
    if (idx == '0) begin
      value = '0;
    end
    return value;
  endfunction

  assign simm    = {{16{ir.low.imm[15]}}, ir.low.imm};
  assign rbIdx   = (ir.opcode == cpuPkg::OpSw) ? ir.rd : ir.low.a.rb; // SW stores rd
  assign isMemOp = (ir.opcode == cpuPkg::OpLw) || (ir.opcode == cpuPkg::OpSw);

  always_comb begin
    case (ir.opcode)
      cpuPkg::OpAdd,
      cpuPkg::OpSub,
      cpuPkg::OpAddi,
      cpuPkg::OpLw: writesReg = 1'b1;
      default:      writesReg = 1'b0;
    endcase
  end

  // Sequencer, one instruction at a time
  always_ff @(posedge sysClk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      state <= cpuPkg::Fetch;
      pc    <= '0;
    end else begin
      case (state)
        cpuPkg::Fetch: begin
          if (!iBusy_i) begin
            state <= cpuPkg::Decode;
          end
        end
        cpuPkg::Decode: begin
          if (ir.opcode == cpuPkg::OpHalt) begin
            state <= cpuPkg::Halted;
          end else begin
            state <= cpuPkg::Execute;
          end
        end
        cpuPkg::Execute: begin
          state <= isMemOp ? cpuPkg::Memory : cpuPkg::Writeback;
        end
        cpuPkg::Memory: begin
          if (!dBusy_i) begin
            state <= cpuPkg::Writeback;
          end
        end
        cpuPkg::Writeback: begin
          state <= cpuPkg::Fetch;
          pc    <= nextPc;
        end
        cpuPkg::Halted: state <= cpuPkg::Halted; // Only reset leaves
        default:        state <= cpuPkg::Fetch;
      endcase
    end
  end

  // Datapath and register file
  always_ff @(posedge sysClk_i) begin
    case (state)
      cpuPkg::Fetch: begin
        if (!iBusy_i) begin
          ir <= iData_i;
        end
      end
      cpuPkg::Decode: begin
        opA <= readReg(ir.ra);
        opB <= readReg(rbIdx);
      end
      cpuPkg::Execute: begin
        case (ir.opcode)
          cpuPkg::OpAdd: result <= opA + opB;
          cpuPkg::OpSub: result <= opA - opB;
          default:       result <= opA + simm; // ADDI and address generation
        endcase
        case (ir.opcode)
          cpuPkg::OpBri:  nextPc <= pc + simm;
          cpuPkg::OpBeqi: nextPc <= (opA == '0) ? pc + simm : pc + 32'd4;
          default:        nextPc <= pc + 32'd4;
        endcase
      end
      cpuPkg::Memory: begin
        if (!dBusy_i && ir.opcode == cpuPkg::OpLw) begin
          result <= dData_i; // Load data replaces the address
        end
      end
      cpuPkg::Writeback: begin
        if (writesReg) begin
          regFile[ir.rd] <= result;
        end
      end
      default: ;
    endcase
  end

  // Requests stay asserted until the cache drops busy
  always_comb begin
    iReq_o.addr  = pc;
    iReq_o.en    = (state == cpuPkg::Fetch);
    iReq_o.we    = 1'b0; // Instruction side is read only
    iReq_o.wdata = '0;

    dReq_o.addr  = result;
    dReq_o.en    = (state == cpuPkg::Memory);
    dReq_o.we    = (ir.opcode == cpuPkg::OpSw);
    dReq_o.wdata = opB;
  end

  assign halted_o = (state == cpuPkg::Halted);

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

  typedef logic [31:0] word_t;   // Data word and register value
  typedef logic [4:0]  regIdx_t; // Register 0 always reads zero
  typedef logic [5:0]  opcode_t;

  // Major opcodes, the program image uses the same numbers
  localparam opcode_t OpAdd  = 6'h00; // rd = ra + rb
  localparam opcode_t OpSub  = 6'h01; // rd = ra - rb
  localparam opcode_t OpAddi = 6'h08; // rd = ra + simm
  localparam opcode_t OpBri  = 6'h2e; // pc = pc + simm
  localparam opcode_t OpBeqi = 6'h2f; // pc = pc + simm when ra is zero
  localparam opcode_t OpLw   = 6'h32; // rd = mem[ra + simm]
  localparam opcode_t OpSw   = 6'h36; // mem[ra + simm] = rd
  localparam opcode_t OpHalt = 6'h3f;

  typedef enum logic [2:0] {
    Fetch,
    Decode,
    Execute,
    Memory,
    Writeback,
    Halted
  } coreState_t;

  // Type A view of the low half, rb sits in the top of the immediate
  typedef struct packed {
    regIdx_t     rb;
    logic [10:0] func;
  } typeA_t;

  typedef union packed {
    logic [15:0] imm; // Type B immediate
    typeA_t      a;
  } instrLow_t;

  typedef struct packed {
    opcode_t   opcode;
    regIdx_t   rd;
    regIdx_t   ra;
    instrLow_t low;
  } instr_t;

endpackage

/* hdl/cpuSubsys.sv */
`timescale 1ns/100ps

module cpuSubsys (
  input  logic            sysClk_i,
  input  logic            arstN_i,
  output memPkg::memReq_t memReq_o,
  input  memPkg::memRsp_t memRsp_i,
  output logic            halted_o
);

  memPkg::cacheReq_t iReq;
  memPkg::cacheReq_t dReq;
  logic              iBusy;
  logic              dBusy;
  cpuPkg::word_t     iData;
  cpuPkg::word_t     dData;
  memPkg::memReq_t   iMemReq;
  memPkg::memReq_t   dMemReq;
  memPkg::memRsp_t   iMemRsp;
  memPkg::memRsp_t   dMemRsp;

  cpuCore core (
    .sysClk_i (sysClk_i),
    .arstN_i  (arstN_i),
    .iReq_o   (iReq),
    .iBusy_i  (iBusy),
    .iData_i  (iData),
    .dReq_o   (dReq),
    .dBusy_i  (dBusy),
    .dData_i  (dData),
    .halted_o (halted_o)
  );

  // Read-only instruction cache
  cacheCtrl iCache (
    .sysClk_i (sysClk_i),
    .arstN_i  (arstN_i),
    .req_i    (iReq),
    .busy_o   (iBusy),
    .data_o   (iData),
    .memReq_o (iMemReq),
    .memRsp_i (iMemRsp)
  );

  cacheCtrl dCache (
    .sysClk_i (sysClk_i),
    .arstN_i  (arstN_i),
    .req_i    (dReq),
    .busy_o   (dBusy),
    .data_o   (dData),
    .memReq_o (dMemReq),
    .memRsp_i (dMemRsp)
  );

  memArbiter arbiter (
    .sysClk_i  (sysClk_i),
    .arstN_i   (arstN_i),
    .iMemReq_i (iMemReq),
    .dMemReq_i (dMemReq),
    .iMemRsp_o (iMemRsp),
    .dMemRsp_o (dMemRsp),
    .memReq_o  (memReq_o),
    .memRsp_i  (memRsp_i)
  );

endmodule

/* hdl/memArbiter.sv */
`timescale 1ns/100ps

module memArbiter (
  input  logic            sysClk_i,
  input  logic            arstN_i,
  // Cache side
  input  memPkg::memReq_t iMemReq_i,
  input  memPkg::memReq_t dMemReq_i,
  output memPkg::memRsp_t iMemRsp_o,
  output memPkg::memRsp_t dMemRsp_o,
  // External bus
  output memPkg::memReq_t memReq_o,
  input  memPkg::memRsp_t memRsp_i
);

  typedef enum logic [1:0] {
    GrantNone,
    GrantInstr,
    GrantData
  } grant_t;

  grant_t grant;
  logic   selData;

  // While free the choice is made combinationally, data cache first
  assign selData = (grant == GrantNone) ? dMemReq_i.valid : (grant == GrantData);

  assign memReq_o = selData ? dMemReq_i : iMemReq_i;

  always_ff @(posedge sysClk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      grant <= GrantNone;
    end else if (memRsp_i.ack) begin
      grant <= GrantNone; // Free for the next choice
    end else if (grant == GrantNone && memReq_o.valid) begin
      grant <= selData ? GrantData : GrantInstr; // Lock until ack
    end
  end

  // Only the granted cache sees the response
  always_comb begin
    dMemRsp_o.ack   = memRsp_i.ack && selData;
    dMemRsp_o.rdata = selData ? memRsp_i.rdata : '0;
    iMemRsp_o.ack   = memRsp_i.ack && !selData;
    iMemRsp_o.rdata = selData ? '0 : memRsp_i.rdata;
  end

endmodule

/* hdl/memPkg.sv */
package memPkg;

  typedef logic [31:0] addr_t; // Byte address, bits 1:0 ignored

  // Direct-mapped geometry, one word per line
  localparam int WordOffsetBits = 2;
  localparam int CacheIndexBits = 4;
  localparam int CacheTagBits   = 26;
  localparam int CacheLines     = 1 << CacheIndexBits;

  typedef logic [CacheIndexBits-1:0] cacheIdx_t;
  typedef logic [CacheTagBits-1:0]   cacheTag_t;

  // External memory bus, request held until ack
  typedef struct packed {
    logic          valid;
    logic          write;
    addr_t         addr;
    cpuPkg::word_t wdata;
  } memReq_t;

  typedef struct packed {
    logic          ack;   // Single-cycle pulse
    cpuPkg::word_t rdata;
  } memRsp_t;

  // Core to cache, precycle address with enable
  typedef struct packed {
    addr_t         addr;
    logic          en;
    logic          we;
    cpuPkg::word_t wdata;
  } cacheReq_t;

endpackage
